/* logic/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address into memory
`define CACHE_ADDR_WIDTH 32

// same word width on cpu and memory side
`define CACHE_DATA_WIDTH 32
`define CACHE_BE_WIDTH   4

// one line is one burst
`define CACHE_LINE_WORDS 4

// geometry
`define CACHE_SETS 64
`define CACHE_WAYS 4

// replacement lfsr start value
`define CACHE_LFSR_SEED 11'd101

`endif

/* logic/cache_pkg.sv */
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

  localparam int WORD_W  = $clog2(`CACHE_LINE_WORDS);  // word within line
  localparam int INDEX_W = $clog2(`CACHE_SETS);
  localparam int BYTE_W  = $clog2(`CACHE_BE_WIDTH);    // byte within word
  localparam int TAG_W   = `CACHE_ADDR_WIDTH - INDEX_W - WORD_W - BYTE_W;
  localparam int WAY_W   = $clog2(`CACHE_WAYS);

  // cpu address, flat or split into lookup fields
  typedef union packed {
    logic [`CACHE_ADDR_WIDTH-1:0] flat;
    struct packed {
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] index;
      logic [WORD_W-1:0]  word;
      logic [BYTE_W-1:0]  byte_off;
    } field;
  } cache_addr_u;

endpackage

`default_nettype wire

/* logic/victim_select.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module victim_select (
  input  wire                           clock,
  input  wire                           reset_n,
  input  wire                           advance,
  input  wire  [`CACHE_WAYS-1:0]        way_valid,
  input  wire  [`CACHE_WAYS-1:0]        way_dirty,
  output logic [cache_pkg::WAY_W-1:0]   victim_way
);

  localparam int WAYS = `CACHE_WAYS;
  localparam int WW   = cache_pkg::WAY_W;

  logic [10:0]   lfsr;
  logic [WW-1:0] rand_way;

  // x^11 + x^9 + 1 stepped two bits at a time
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      lfsr <= `CACHE_LFSR_SEED;
    else if (advance)
      lfsr <= {lfsr[1:0] ^ lfsr[3:2], lfsr[10:2]};
  end

  assign rand_way = lfsr[WW-1:0];

  always_comb begin
    logic          found;
    logic [WW-1:0] probe;
    found      = 1'b0;
    probe      = rand_way;
    victim_way = rand_way;  // random way if every line is dirty
    for (int k = 0; k < WAYS; k++) begin
      if (!found && !way_valid[k]) begin
        victim_way = WW'(k);
        found      = 1'b1;
      end
    end
    // set full so look for a clean line from the random way on
    for (int k = 0; k < WAYS; k++) begin
      probe = rand_way + WW'(k);  // wraps since ways are a power of two
      if (!found && !way_dirty[probe]) begin
        victim_way = probe;
        found      = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/tag_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module tag_store (
  input  wire                           clock,
  input  wire                           reset_n,
  input  wire  [`CACHE_ADDR_WIDTH-1:0]  cpu_addr,
  input  wire                           tag_write,
  input  wire  [cache_pkg::WAY_W-1:0]   tag_write_way,
  input  wire                           tag_write_valid,
  input  wire                           tag_write_dirty,
  input  wire                           install,
  input  wire  [cache_pkg::WAY_W-1:0]   install_way,
  input  wire  [`CACHE_ADDR_WIDTH-1:0]  install_addr,
  input  wire                           install_dirty,
  output logic [cache_pkg::WAY_W-1:0]   hit_way,
  output logic                          any_hit,
  output logic [`CACHE_WAYS-1:0]        way_valid,
  output logic [`CACHE_WAYS-1:0]        way_dirty,
  output logic [cache_pkg::TAG_W-1:0]   victim_tag
);

  localparam int WAYS = `CACHE_WAYS;
  localparam int SETS = `CACHE_SETS;
  localparam int TW   = cache_pkg::TAG_W;
  localparam int WW   = cache_pkg::WAY_W;

  cache_pkg::cache_addr_u req_a;
  cache_pkg::cache_addr_u ins_a;

  logic [TW-1:0]   tag_q   [WAYS][SETS];
  logic [SETS-1:0] valid_q [WAYS];
  logic [SETS-1:0] dirty_q [WAYS];
  logic [WAYS-1:0] way_hit;
  logic [WW-1:0]   wr_way;

  assign req_a = cpu_addr;
  assign ins_a = install_addr;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      way_valid[w] = valid_q[w][req_a.field.index];
      way_dirty[w] = dirty_q[w][req_a.field.index];
      way_hit[w]   = way_valid[w] && (tag_q[w][req_a.field.index] == req_a.field.tag);
      if (way_hit[w])
        hit_way = WW'(w);
    end
  end

  assign any_hit    = |way_hit;
  assign victim_tag = tag_q[tag_write_way][req_a.field.index];

  // on a hit the update is a cpu write, otherwise it retires the victim
  assign wr_way = any_hit ? hit_way : tag_write_way;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
    end else if (install) begin
      valid_q[install_way][ins_a.field.index] <= 1'b1;
      dirty_q[install_way][ins_a.field.index] <= install_dirty;
    end else if (tag_write) begin
      valid_q[wr_way][req_a.field.index] <= tag_write_valid;
      dirty_q[wr_way][req_a.field.index] <= tag_write_dirty;
    end
  end

  always_ff @(posedge clock) begin
    if (install)
      tag_q[install_way][ins_a.field.index] <= ins_a.field.tag;
  end

  a_one_hit: assert property (@(posedge clock) disable iff (!reset_n) $onehot0(way_hit));

endmodule

`default_nettype wire

/* logic/data_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module data_store (
  input  wire                                           clock,
  input  wire  [`CACHE_ADDR_WIDTH-1:0]                  cpu_addr,
  input  wire  [`CACHE_BE_WIDTH-1:0]                    cpu_wr_be,
  input  wire  [`CACHE_DATA_WIDTH-1:0]                  cpu_wr_data,
  input  wire                                           write_hit,
  input  wire  [cache_pkg::WAY_W-1:0]                   hit_way,
  input  wire  [cache_pkg::WAY_W-1:0]                   wb_way,
  input  wire  [cache_pkg::WORD_W-1:0]                  wb_word,
  input  wire                                           install,
  input  wire  [cache_pkg::WAY_W-1:0]                   install_way,
  input  wire  [cache_pkg::INDEX_W-1:0]                 install_index,
  input  wire  [`CACHE_LINE_WORDS*`CACHE_DATA_WIDTH-1:0] install_line,
  output logic [`CACHE_DATA_WIDTH-1:0]                  rd_word,
  output logic [`CACHE_DATA_WIDTH-1:0]                  wb_data
);

  localparam int WAYS = `CACHE_WAYS;
  localparam int SETS = `CACHE_SETS;
  localparam int LW   = `CACHE_LINE_WORDS;
  localparam int DW   = `CACHE_DATA_WIDTH;
  localparam int BW   = `CACHE_BE_WIDTH;
  localparam int BITS = DW / BW;  // bits per byte lane

  cache_pkg::cache_addr_u req_a;

  logic [DW-1:0] data_q [WAYS][SETS][LW];

  assign req_a = cpu_addr;

  always_ff @(posedge clock) begin
    if (install) begin
      for (int w = 0; w < LW; w++)
        data_q[install_way][install_index][w] <= install_line[w*DW +: DW];
    end else if (write_hit) begin
      for (int b = 0; b < BW; b++) begin
        if (cpu_wr_be[b])
          data_q[hit_way][req_a.field.index][req_a.field.word][b*BITS +: BITS] <=
            cpu_wr_data[b*BITS +: BITS];
      end
    end
  end

  assign rd_word = data_q[hit_way][req_a.field.index][req_a.field.word];
  assign wb_data = data_q[wb_way][req_a.field.index][wb_word];  // victim shares the set

endmodule

`default_nettype wire

/* logic/line_fill.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module line_fill (
  input  wire                                            clock,
  input  wire                                            reset_n,
  input  wire                                            fill_start,
  input  wire  [`CACHE_ADDR_WIDTH-1:0]                   cpu_addr,
  input  wire                                            cpu_wr,
  input  wire  [`CACHE_BE_WIDTH-1:0]                     cpu_wr_be,
  input  wire  [`CACHE_DATA_WIDTH-1:0]                   cpu_wr_data,
  input  wire                                            mem_rd_valid,
  input  wire  [`CACHE_DATA_WIDTH-1:0]                   mem_rd_data,
  output logic                                           line_ready,
  output logic [`CACHE_LINE_WORDS*`CACHE_DATA_WIDTH-1:0] line,
  output logic [cache_pkg::INDEX_W-1:0]                  fill_index,
  output logic                                           fill_dirty
);

  localparam int LW   = `CACHE_LINE_WORDS;
  localparam int DW   = `CACHE_DATA_WIDTH;
  localparam int BW   = `CACHE_BE_WIDTH;
  localparam int BITS = DW / BW;

  cache_pkg::cache_addr_u req_a;

  logic                           open_q;
  logic [cache_pkg::WORD_W-1:0]   ptr_q;  // offset of the next beat
  logic [LW-1:0]                  word_valid_q;
  logic [LW-1:0]                  ptr_bit;
  logic                           last_beat;
  logic [LW*DW-1:0]               line_d;

  assign req_a     = cpu_addr;
  assign ptr_bit   = LW'(1) << ptr_q;
  assign last_beat = mem_rd_valid && (&(word_valid_q | ptr_bit));

  always_comb begin
    line_d = line;
    if (mem_rd_valid)
      line_d[ptr_q*DW +: DW] = mem_rd_data;
    // fold in the stalled cpu write so the installed copy is current
    if (last_beat && cpu_wr) begin
      for (int b = 0; b < BW; b++) begin
        if (cpu_wr_be[b])
          line_d[req_a.field.word*DW + b*BITS +: BITS] = cpu_wr_data[b*BITS +: BITS];
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      open_q       <= 1'b0;
      ptr_q        <= '0;
      word_valid_q <= '0;
      fill_index   <= '0;
      fill_dirty   <= 1'b0;
      line_ready   <= 1'b0;
    end else begin
      line_ready <= last_beat;
      if (fill_start) begin
        open_q       <= 1'b1;
        ptr_q        <= req_a.field.word;  // wrap starts at requested word
        word_valid_q <= '0;
        fill_index   <= req_a.field.index;
      end else if (mem_rd_valid) begin
        ptr_q        <= ptr_q + 1'b1;
        word_valid_q <= word_valid_q | ptr_bit;
        if (last_beat) begin
          open_q     <= 1'b0;
          fill_dirty <= cpu_wr;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    line <= line_d;
  end

  a_beat_in_fill: assert property (@(posedge clock) disable iff (!reset_n)
    mem_rd_valid |-> open_q);

endmodule

`default_nettype wire

/* logic/cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_ctrl (
  input  wire                           clock,
  input  wire                           reset_n,
  input  wire  [`CACHE_ADDR_WIDTH-1:0]  cpu_addr,
  input  wire                           cpu_rd,
  input  wire                           cpu_wr,
  input  wire                           any_hit,
  input  wire  [`CACHE_WAYS-1:0]        way_valid,
  input  wire  [`CACHE_WAYS-1:0]        way_dirty,
  input  wire  [cache_pkg::WAY_W-1:0]   victim_way,
  input  wire  [cache_pkg::TAG_W-1:0]   victim_tag,
  input  wire                           mem_waitrequest,
  input  wire                           line_ready,
  output logic                          cpu_waitrequest,
  output logic                          cpu_rd_valid,
  output logic                          write_hit,
  output logic                          tag_write,
  output logic [cache_pkg::WAY_W-1:0]   tag_write_way,
  output logic                          tag_write_valid,
  output logic                          tag_write_dirty,
  output logic                          advance,
  output logic                          fill_start,
  output logic [cache_pkg::WAY_W-1:0]   fill_way,
  output logic [cache_pkg::WAY_W-1:0]   wb_way,
  output logic [cache_pkg::WORD_W-1:0]  wb_word,
  output logic [`CACHE_ADDR_WIDTH-1:0]  mem_addr,
  output logic                          mem_rd,
  output logic                          mem_wr
);

  localparam int AW = `CACHE_ADDR_WIDTH;
  localparam int WDW = cache_pkg::WORD_W;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_WB   = 2'd1;  // victim burst out
  localparam logic [1:0] ST_RD   = 2'd2;  // read request pending
  localparam logic [1:0] ST_FILL = 2'd3;  // waiting on read beats

  cache_pkg::cache_addr_u req_a;
  cache_pkg::cache_addr_u wb_a;
  cache_pkg::cache_addr_u fill_a;

  logic [1:0] state_q;
  logic       hit_ok;
  logic       miss;
  logic       victim_dirty;
  logic       wb_start;
  logic       wb_last;

  assign req_a = cpu_addr;

  always_comb begin
    wb_a                  = '0;
    wb_a.field.tag        = victim_tag;
    wb_a.field.index      = req_a.field.index;
    fill_a                = req_a;
    fill_a.field.byte_off = '0;
  end

  assign hit_ok       = (state_q == ST_IDLE) && any_hit;
  assign miss         = (state_q == ST_IDLE) && (cpu_rd || cpu_wr) && !any_hit;
  assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
  assign wb_start     = miss && victim_dirty;
  assign wb_last      = (wb_word == WDW'(`CACHE_LINE_WORDS - 1));

  assign cpu_waitrequest = (cpu_rd || cpu_wr) && !hit_ok;
  assign cpu_rd_valid    = cpu_rd && hit_ok;
  assign write_hit       = cpu_wr && hit_ok;

  // write hit marks dirty, writeback start drops the victim
  assign tag_write       = write_hit || wb_start;
  assign tag_write_way   = victim_way;
  assign tag_write_valid = write_hit;
  assign tag_write_dirty = write_hit;

  assign fill_start = (miss && !victim_dirty) ||
                      ((state_q == ST_WB) && !mem_waitrequest && wb_last);
  assign advance    = fill_start;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= ST_IDLE;
      mem_rd   <= 1'b0;
      mem_wr   <= 1'b0;
      mem_addr <= '0;
      wb_word  <= '0;
      wb_way   <= '0;
      fill_way <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (miss) begin
            fill_way <= victim_way;
            if (victim_dirty) begin
              state_q  <= ST_WB;
              mem_wr   <= 1'b1;
              mem_addr <= wb_a.flat;  // line base of the victim
              wb_way   <= victim_way;
              wb_word  <= '0;
            end else begin
              state_q  <= ST_RD;
              mem_rd   <= 1'b1;
              mem_addr <= fill_a.flat;
            end
          end
        end
        ST_WB: begin
          if (!mem_waitrequest) begin
            wb_word <= wb_word + 1'b1;
            if (wb_last) begin
              state_q  <= ST_RD;
              mem_wr   <= 1'b0;
              mem_rd   <= 1'b1;
              mem_addr <= fill_a.flat;
            end else begin
              mem_addr <= mem_addr + AW'(`CACHE_BE_WIDTH);
            end
          end
        end
        ST_RD: begin
          if (!mem_waitrequest) begin
            state_q <= ST_FILL;
            mem_rd  <= 1'b0;
          end
        end
        default: begin
          if (line_ready)
            state_q <= ST_IDLE;
        end
      endcase
    end
  end

  a_rd_wr_excl: assert property (@(posedge clock) disable iff (!reset_n) !(mem_rd && mem_wr));

  // a completed line must find the controller waiting for it
  a_ready_in_fill: assert property (@(posedge clock) disable iff (!reset_n)
    line_ready |-> (state_q == ST_FILL));

endmodule

`default_nettype wire

/* logic/cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_top (
  input  wire                           clock,
  input  wire                           reset_n,
  input  wire  [`CACHE_ADDR_WIDTH-1:0]  cpu_addr,
  input  wire                           cpu_rd,
  input  wire                           cpu_wr,
  input  wire  [`CACHE_BE_WIDTH-1:0]    cpu_wr_be,
  input  wire  [`CACHE_DATA_WIDTH-1:0]  cpu_wr_data,
  output logic                          cpu_rd_valid,
  output logic [`CACHE_DATA_WIDTH-1:0]  cpu_rd_data,
  output logic                          cpu_waitrequest,
  output logic [`CACHE_ADDR_WIDTH-1:0]  mem_addr,
  output logic [`CACHE_DATA_WIDTH-1:0]  mem_wr_data,
  input  wire  [`CACHE_DATA_WIDTH-1:0]  mem_rd_data,
  input  wire                           mem_rd_valid,
  input  wire                           mem_waitrequest,
  output logic                          mem_rd,
  output logic                          mem_wr
);

  cache_pkg::cache_addr_u cpu_a;
  cache_pkg::cache_addr_u install_a;

  logic [cache_pkg::WAY_W-1:0]   hit_way, victim_way, tag_write_way, fill_way, wb_way;
  logic [cache_pkg::WORD_W-1:0]  wb_word;
  logic [cache_pkg::TAG_W-1:0]   victim_tag;
  logic [cache_pkg::INDEX_W-1:0] fill_index;
  logic [`CACHE_WAYS-1:0]        way_valid, way_dirty;
  logic [`CACHE_LINE_WORDS*`CACHE_DATA_WIDTH-1:0] line;
  logic any_hit, write_hit, tag_write, tag_write_valid, tag_write_dirty;
  logic advance, fill_start, line_ready, fill_dirty;

  assign cpu_a = cpu_addr;

  // held request's tag in the set the fill buffer recorded
  always_comb begin
    install_a             = '0;
    install_a.field.tag   = cpu_a.field.tag;
    install_a.field.index = fill_index;
  end

  victim_select i_victim_select (.clock, .reset_n, .advance, .way_valid, .way_dirty,
    .victim_way);

  tag_store i_tag_store (.clock, .reset_n, .cpu_addr, .tag_write, .tag_write_way,
    .tag_write_valid, .tag_write_dirty, .install(line_ready), .install_way(fill_way),
    .install_addr(install_a.flat), .install_dirty(fill_dirty), .hit_way, .any_hit,
    .way_valid, .way_dirty, .victim_tag);

  data_store i_data_store (.clock, .cpu_addr, .cpu_wr_be, .cpu_wr_data, .write_hit, .hit_way,
    .wb_way, .wb_word, .install(line_ready), .install_way(fill_way),
    .install_index(fill_index), .install_line(line), .rd_word(cpu_rd_data),
    .wb_data(mem_wr_data));

  line_fill i_line_fill (.clock, .reset_n, .fill_start, .cpu_addr, .cpu_wr, .cpu_wr_be,
    .cpu_wr_data, .mem_rd_valid, .mem_rd_data, .line_ready, .line, .fill_index, .fill_dirty);

  cache_ctrl i_cache_ctrl (.clock, .reset_n, .cpu_addr, .cpu_rd, .cpu_wr, .any_hit,
    .way_valid, .way_dirty, .victim_way, .victim_tag, .mem_waitrequest, .line_ready,
    .cpu_waitrequest, .cpu_rd_valid, .write_hit, .tag_write, .tag_write_way,
    .tag_write_valid, .tag_write_dirty, .advance, .fill_start, .fill_way, .wb_way,
    .wb_word, .mem_addr, .mem_rd, .mem_wr);

endmodule

`default_nettype wire

/* verif/cache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

  localparam int N_OPS     = 28;
  localparam int LIMIT     = 400 * N_OPS + 20;  // cycles per table entry plus reset
  localparam int MEM_WORDS = 4096;
  localparam logic [2:0] WB_ANY   = 3'd7;  // traffic depends on the lfsr
  localparam logic [1:0] FILL_ANY = 2'd3;

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] data;
    logic [2:0]  wb;    // expected write beats
    logic [1:0]  fill;  // expected read requests
  } op_t;

  logic        clock;
  logic        reset_n;
  logic [31:0] cpu_addr, cpu_wr_data, cpu_rd_data;
  logic [3:0]  cpu_wr_be;
  logic        cpu_rd, cpu_wr, cpu_rd_valid, cpu_waitrequest;
  logic [31:0] mem_addr, mem_wr_data, mem_rd_data;
  logic        mem_rd, mem_wr, mem_rd_valid, mem_waitrequest;

  op_t         ops [N_OPS];
  logic [7:0]  shadow [0:4*MEM_WORDS-1];  // expected bytes
  logic [31:0] mem_model [0:MEM_WORDS-1];
  logic [31:0] cur_addr;
  integer      seed = 96;
  int          error_count = 0;
  int          check_count = 0;
  int          wb_beats = 0;
  int          fill_reqs = 0;

  cache_top i_cache_top (.clock, .reset_n, .cpu_addr, .cpu_rd, .cpu_wr, .cpu_wr_be,
    .cpu_wr_data, .cpu_rd_valid, .cpu_rd_data, .cpu_waitrequest, .mem_addr, .mem_wr_data,
    .mem_rd_data, .mem_rd_valid, .mem_waitrequest, .mem_rd, .mem_wr);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] init_word(input logic [31:0] byte_addr);
    return (byte_addr * 32'h9e37_79b1) ^ 32'h3c5a_a5c3;
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    logic [31:0] w;
    for (int b = 0; b < 4; b++)
      w[b*8 +: 8] = shadow[{addr[13:2], 2'(b)}];
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic load_op(input int i, input logic wr, input logic [31:0] addr,
                         input logic [3:0] be, input logic [31:0] data,
                         input logic [2:0] wb, input logic [1:0] fill);
    ops[i] = {wr, addr, be, data, wb, fill};
  endtask

  // set 4 and set 8 for hits and merges, set 16 for five conflicting lines
  task automatic load_table();
    load_op(0,  1'b0, 32'h2048, 4'h0, 32'h0000_0000, 3'd0, 2'd1);
    load_op(1,  1'b0, 32'h204c, 4'h0, 32'h0000_0000, 3'd0, 2'd0);
    load_op(2,  1'b1, 32'h2044, 4'h3, 32'hdead_beef, 3'd0, 2'd0);
    load_op(3,  1'b0, 32'h2044, 4'h0, 32'h0000_0000, 3'd0, 2'd0);
    load_op(4,  1'b1, 32'h3084, 4'ha, 32'h1122_3344, 3'd0, 2'd1);
    load_op(5,  1'b0, 32'h3084, 4'h0, 32'h0000_0000, 3'd0, 2'd0);
    load_op(6,  1'b1, 32'h308c, 4'hf, 32'hcafe_f00d, 3'd0, 2'd0);
    load_op(7,  1'b1, 32'h0104, 4'hf, 32'ha0a0_0001, 3'd0, 2'd1);
    load_op(8,  1'b1, 32'h0508, 4'hc, 32'hb0b0_0002, 3'd0, 2'd1);
    load_op(9,  1'b1, 32'h090c, 4'h1, 32'hc0c0_0003, 3'd0, 2'd1);
    load_op(10, 1'b1, 32'h0d00, 4'h6, 32'hd0d0_0004, 3'd0, 2'd1);
    load_op(11, 1'b0, 32'h1104, 4'h0, 32'h0000_0000, 3'd4, 2'd1);  // all dirty
    load_op(12, 1'b0, 32'h0104, 4'h0, 32'h0000_0000, 3'd0, FILL_ANY);
    load_op(13, 1'b0, 32'h0508, 4'h0, 32'h0000_0000, 3'd0, FILL_ANY);
    load_op(14, 1'b0, 32'h090c, 4'h0, 32'h0000_0000, 3'd0, FILL_ANY);
    load_op(15, 1'b0, 32'h0d00, 4'h0, 32'h0000_0000, 3'd0, FILL_ANY);
    load_op(16, 1'b1, 32'h0100, 4'hf, 32'h1111_2222, 3'd0, 2'd0);
    load_op(17, 1'b1, 32'h0500, 4'h9, 32'h3333_4444, 3'd0, 2'd0);
    load_op(18, 1'b1, 32'h0900, 4'h4, 32'h5555_6666, 3'd0, 2'd0);
    load_op(19, 1'b1, 32'h0d0c, 4'hf, 32'h7777_8888, 3'd0, 2'd0);
    load_op(20, 1'b1, 32'h1108, 4'h3, 32'h9999_aaaa, 3'd4, 2'd1);
    load_op(21, 1'b0, 32'h1108, 4'h0, 32'h0000_0000, 3'd0, 2'd0);
    load_op(22, 1'b0, 32'h0100, 4'h0, 32'h0000_0000, WB_ANY, FILL_ANY);
    load_op(23, 1'b0, 32'h0500, 4'h0, 32'h0000_0000, WB_ANY, FILL_ANY);
    load_op(24, 1'b0, 32'h0900, 4'h0, 32'h0000_0000, WB_ANY, FILL_ANY);
    load_op(25, 1'b0, 32'h0d0c, 4'h0, 32'h0000_0000, WB_ANY, FILL_ANY);
    load_op(26, 1'b0, 32'h308c, 4'h0, 32'h0000_0000, 3'd0, 2'd0);
    load_op(27, 1'b0, 32'h2040, 4'h0, 32'h0000_0000, 3'd0, 2'd0);
  endtask

  // memory model samples at negedge and drives after the rising edge
  initial begin
    logic [31:0] rnd;
    logic [31:0] burst_addr;
    logic [31:0] rd_addr;
    int          burst_len;
    int          rd_left;
    burst_addr      = '0;
    rd_addr         = '0;
    burst_len       = 0;
    rd_left         = 0;
    mem_rd_valid    = 1'b0;
    mem_rd_data     = '0;
    mem_waitrequest = 1'b1;
    for (int w = 0; w < MEM_WORDS; w++)
      mem_model[w] = init_word(32'(w * 4));
    forever begin
      @(negedge clock);
      if ((mem_rd || mem_wr) && mem_addr >= 32'h4000) begin
        error_count++;
        $display("Memory access outside the modeled range at %0t ns", $time);
      end
      if (mem_wr && !mem_waitrequest) begin
        if (burst_len == 0)
          check("mem_addr line offset", 32'd0, 32'(mem_addr[3:0]));
        else
          check("mem_addr write beat", burst_addr + 32'd4, mem_addr);
        check("mem_addr set", 32'(cur_addr[9:4]), 32'(mem_addr[9:4]));
        check("mem_wr_data", shadow_word(mem_addr), mem_wr_data);
        mem_model[mem_addr[13:2]] = mem_wr_data;
        burst_addr = mem_addr;
        burst_len++;
        wb_beats++;
      end
      if (mem_rd && !mem_waitrequest) begin
        check("mem_addr read request", {cur_addr[31:2], 2'b00}, mem_addr);
        if (burst_len != 0)
          check("write burst length", 32'd4, 32'(burst_len));
        burst_len = 0;
        rd_addr   = mem_addr;
        rd_left   = 4;
        fill_reqs++;
      end
      @(posedge clock);
      #1;
      rnd = $random(seed);
      mem_waitrequest = (rnd[2:0] < 3'd3);
      if (rd_left != 0 && rnd[4:3] != 2'd0) begin
        mem_rd_valid = 1'b1;
        mem_rd_data  = mem_model[rd_addr[13:2]];
        rd_addr      = {rd_addr[31:4], rd_addr[3:2] + 2'd1, 2'b00};  // wrap in line
        rd_left--;
      end else begin
        mem_rd_valid = 1'b0;
      end
    end
  end

  initial begin
    op_t         op;
    logic [31:0] word;
    int          waits;
    int          wb_before;
    int          fill_before;
    reset_n     = 1'b0;
    cpu_addr    = '0;
    cpu_rd      = 1'b0;
    cpu_wr      = 1'b0;
    cpu_wr_be   = '0;
    cpu_wr_data = '0;
    cur_addr    = '0;
    load_table();
    for (int w = 0; w < MEM_WORDS; w++) begin
      word = init_word(32'(w * 4));
      for (int b = 0; b < 4; b++)
        shadow[w*4 + b] = word[b*8 +: 8];
    end
    repeat (10) @(posedge clock);
    #1;
    reset_n = 1'b1;
    @(negedge clock);
    check("mem_rd after reset", 32'd0, 32'(mem_rd));
    check("mem_wr after reset", 32'd0, 32'(mem_wr));
    check("cpu_rd_valid after reset", 32'd0, 32'(cpu_rd_valid));
    @(posedge clock);
    #1;
    for (int i = 0; i < N_OPS; i++) begin
      op          = ops[i];
      wb_before   = wb_beats;
      fill_before = fill_reqs;
      waits       = 0;
      cur_addr    = op.addr;
      cpu_addr    = op.addr;
      cpu_rd      = !op.wr;
      cpu_wr      = op.wr;
      cpu_wr_be   = op.be;
      cpu_wr_data = op.data;
      @(negedge clock);
      while (cpu_waitrequest) begin
        check("cpu_rd_valid while stalled", 32'd0, 32'(cpu_rd_valid));
        waits++;
        @(negedge clock);
      end
      if (op.wr) begin
        for (int b = 0; b < 4; b++) begin
          if (op.be[b])
            shadow[{op.addr[13:2], 2'(b)}] = op.data[b*8 +: 8];
        end
      end else begin
        check("cpu_rd_valid", 32'd1, 32'(cpu_rd_valid));
        check("cpu_rd_data", shadow_word(op.addr), cpu_rd_data);
      end
      @(posedge clock);
      #1;
      cpu_rd = 1'b0;
      cpu_wr = 1'b0;
      if (op.wb != WB_ANY)
        check("write beats", 32'(op.wb), 32'(wb_beats - wb_before));
      if (op.fill != FILL_ANY)
        check("read requests", 32'(op.fill), 32'(fill_reqs - fill_before));
      if (op.wb == 3'd0 && op.fill == 2'd0)
        check("hit wait cycles", 32'd0, 32'(waits));  // hits finish in the request cycle
    end
    repeat (4) @(posedge clock);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
logic/cache_pkg.sv
logic/victim_select.sv
logic/tag_store.sv
logic/data_store.sv
logic/line_fill.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/cache_tb.sv

/* Makefile */
# Verilator build and run of the cache testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cache_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
PASS_MSG  = Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
